/* source/ex_op_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Operation and state encodings of the execute unit
//////////////////////////////////////////////////////////////////////

package ex_op_pkg;

  // Target unit of an issued request
  typedef enum logic {
    EX_UNIT_ALU = 1'b0,
    EX_UNIT_DIV = 1'b1
  } ex_unit_e;

  // Single-cycle ALU operations
  // Codes 6 and 7 are unused and give a zero result
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_SLL = 3'd2,
    ALU_SRL = 3'd3,
    ALU_SRA = 3'd4,
    ALU_CLZ = 3'd5
  } alu_opcode_e;

  // Divider operations
  // Bit 1 picks the remainder, the signed forms are DIV and REM
  typedef enum logic [1:0] {
    DIV_DIV  = 2'd0,
    DIV_DIVU = 2'd1,
    DIV_REM  = 2'd2,
    DIV_REMU = 2'd3
  } div_opcode_e;

  // Serial divider FSM states
  typedef enum logic [1:0] {
    DIV_IDLE   = 2'd0,
    DIV_DIVIDE = 2'd1,
    DIV_DUMMY  = 2'd2,
    DIV_FINISH = 2'd3
  } div_state_e;

endpackage

`default_nettype wire

/* source/ex_data_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Request and result words of the execute unit
//////////////////////////////////////////////////////////////////////

package ex_data_pkg;
  import ex_op_pkg::*;

  // Issue word from the host
  // Only the opcode of the selected unit is meaningful
  typedef struct packed {
    ex_unit_e    unit;
    alu_opcode_e alu_op;
    div_opcode_e div_op;
    logic        data_ind_timing;
    logic [31:0] op_a;
    logic [31:0] op_b;
  } ex_req_t;

  // Committed result
  typedef struct packed {
    logic [31:0] result;
    // Set when the value came out of the divider
    logic        from_div;
  } ex_res_t;

endpackage

`default_nettype wire

/* source/ex_alu.sv */
`default_nettype none

module ex_alu import ex_op_pkg::*; (
  // Request operands
  input  alu_opcode_e op_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  // Leading-zero counter borrowed by the divider
  input  logic        clz_en_i,
  input  logic [31:0] clz_data_rev_i,
  // Left shift of op_b borrowed by the divider
  input  logic        shift_en_i,
  input  logic [5:0]  shift_amt_i,
  // Results
  output logic [5:0]  clz_result_o,
  output logic [31:0] op_b_shifted_o,
  output logic [31:0] result_o
);

  logic [31:0] adder_b;
  logic [31:0] adder_res;
  logic        is_sub;
  logic        shift_left;
  logic        shift_arith;
  logic [31:0] shift_src;
  logic [5:0]  shift_amt;
  logic [31:0] shift_in;
  logic [32:0] shift_ext;
  logic [31:0] shift_out;
  logic [31:0] clz_in;
  logic [5:0]  clz_cnt;

  // Bit reversal of a word
  function automatic logic [31:0] rev32(input logic [31:0] d);
    for (int i = 0; i < 32; i++) begin
      rev32[i] = d[31-i];
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////////////////////////

  // Subtract as add of the inverted operand plus carry in
  assign is_sub    = (op_i == ALU_SUB);
  assign adder_b   = is_sub ? ~op_b_i : op_b_i;
  assign adder_res = op_a_i + adder_b + {31'd0, is_sub};

  //////////////////////////////////////////////////////////////////////
  // Barrel shifter
  //////////////////////////////////////////////////////////////////////

  // Divider request forces a left shift of op_b
  assign shift_left  = shift_en_i || (op_i == ALU_SLL);
  assign shift_arith = !shift_en_i && (op_i == ALU_SRA);
  assign shift_src   = shift_en_i ? op_b_i : op_a_i;
  // Divider amount can reach 32 and then clears the word
  assign shift_amt   = shift_en_i ? shift_amt_i : {1'b0, op_b_i[4:0]};

  // Left shifts run through the right shifter on reversed data
  assign shift_in  = shift_left ? rev32(shift_src) : shift_src;
  // Extra top bit carries the fill value
  assign shift_ext = $signed({shift_arith & shift_in[31], shift_in}) >>> shift_amt;
  assign shift_out = shift_left ? rev32(shift_ext[31:0]) : shift_ext[31:0];

  assign op_b_shifted_o = shift_out;

  //////////////////////////////////////////////////////////////////////
  // Leading-zero counter
  //////////////////////////////////////////////////////////////////////

  // Works on reversed data, so the lowest set bit gives the count
  assign clz_in = clz_en_i ? clz_data_rev_i : rev32(op_a_i);

  always_comb begin
    // All-zero word counts as 32
    clz_cnt = 6'd32;
    for (int i = 31; i >= 0; i--) begin
      if (clz_in[i]) begin
        clz_cnt = 6'(i);
      end
    end
  end

  assign clz_result_o = clz_cnt;

  // Result select
  always_comb begin
    case (op_i)
      ALU_ADD,
      ALU_SUB: result_o = adder_res;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA: result_o = shift_out;
      ALU_CLZ: result_o = {26'd0, clz_cnt};
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/ex_div.sv */
`default_nettype none

module ex_div import ex_op_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Request
  input  div_opcode_e operator_i,
  input  logic        data_ind_timing_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  // Leading-zero counter in the ALU
  output logic        alu_clz_en_o,
  output logic [31:0] alu_clz_data_rev_o,
  input  logic [5:0]  alu_clz_result_i,
  // Left shifter in the ALU
  output logic        alu_shift_en_o,
  output logic [5:0]  alu_shift_amt_o,
  input  logic [31:0] alu_op_b_shifted_i,
  // Handshakes
  input  logic        valid_i,
  output logic        ready_o,
  input  logic        ready_i,
  output logic        valid_o,
  output logic [31:0] result_o
);

  div_state_e  state_q, state_d;
  logic [5:0]  cnt_q, cnt_d;
  logic [5:0]  dummy_cnt;
  logic        cnt_zero;
  logic        init_en;
  logic        step_en;
  logic        dummy_en;
  logic        div_signed;
  logic        div_rem;
  logic        op_b_neg;
  logic        op_b_zero;
  logic        signs_differ;
  logic [31:0] clz_data;
  logic [31:0] init_rem;
  logic        comp_out;
  logic [31:0] rem_q;
  logic [31:0] quot_q;
  logic [31:0] divisor_q;
  logic        comp_inv_q;
  logic        res_inv_q;
  logic        div_rem_q;
  logic [31:0] res_sel;

  // Operator decode
  assign div_signed   = (operator_i == DIV_DIV) || (operator_i == DIV_REM);
  assign div_rem      = (operator_i == DIV_REM) || (operator_i == DIV_REMU);
  assign op_b_neg     = div_signed && op_b_i[31];
  assign op_b_zero    = (op_b_i == 32'd0);
  assign signs_differ = div_signed && (op_a_i[31] ^ op_b_neg);

  //////////////////////////////////////////////////////////////////////
  // Divisor normalisation through the ALU
  //////////////////////////////////////////////////////////////////////

  // Negative divisor is inverted to count leading ones
  // Shifted up by one so the sign bit survives the normalising shift
  assign clz_data = op_b_neg ? {~op_b_i[30:0], 1'b1} : op_b_i;

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      alu_clz_data_rev_o[i] = clz_data[31-i];
    end
  end

  assign alu_clz_en_o    = valid_i;
  assign alu_shift_en_o  = valid_i;
  // Shift the divisor by its own leading count
  assign alu_shift_amt_o = alu_clz_result_i;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Work on the dividend magnitude when the signs differ
  assign init_rem = signs_differ ? (32'd0 - op_a_i) : op_a_i;

  // Compare magnitudes
  // Negative divisor flips the sense of the compare
  // A zero remainder never subtracts unless dividing by zero
  assign comp_out = ((rem_q == divisor_q) || ((rem_q > divisor_q) ^ comp_inv_q))
                    && ((rem_q != 32'd0) || op_b_zero);

  // Remainder, quotient and divisor shift register
  always_ff @(posedge clk) begin
    if (init_en) begin
      rem_q     <= init_rem;
      divisor_q <= alu_op_b_shifted_i;
      quot_q    <= '0;
    end else if (step_en) begin
      // Divisor moves down with sign fill
      divisor_q <= {comp_inv_q, divisor_q[31:1]};
      quot_q    <= {quot_q[30:0], comp_out};
      if (comp_out) begin
        rem_q <= rem_q - divisor_q;
      end
    end
  end

  // Output select and sign fix
  assign res_sel  = div_rem_q ? rem_q : quot_q;
  assign result_o = res_inv_q ? (32'd0 - res_sel) : res_sel;

  //////////////////////////////////////////////////////////////////////
  // Step counter
  //////////////////////////////////////////////////////////////////////

  // Padding that brings every division to 33 steps
  assign dummy_cnt = 6'd32 - alu_clz_result_i;
  assign cnt_zero  = (cnt_q == 6'd0);

  always_comb begin
    if (init_en) begin
      cnt_d = alu_clz_result_i;
    end else if (dummy_en) begin
      // One padding cycle is spent loading the counter
      cnt_d = dummy_cnt - 6'd1;
    end else if (!cnt_zero) begin
      cnt_d = cnt_q - 6'd1;
    end else begin
      cnt_d = cnt_q;
    end
  end

  // FSM
  always_comb begin
    state_d  = state_q;
    valid_o  = 1'b0;
    ready_o  = 1'b0;
    init_en  = 1'b0;
    step_en  = 1'b0;
    dummy_en = 1'b0;

    case (state_q)
      DIV_IDLE: begin
        init_en = 1'b1;
        state_d = DIV_DIVIDE;
      end
      DIV_DIVIDE: begin
        step_en = 1'b1;
        // Counter at zero marks the last step
        if (cnt_zero) begin
          if (data_ind_timing_i && (dummy_cnt != 6'd0)) begin
            dummy_en = 1'b1;
            state_d  = DIV_DUMMY;
          end else begin
            state_d = DIV_FINISH;
          end
        end
      end
      DIV_DUMMY: begin
        if (cnt_zero) begin
          state_d = DIV_FINISH;
        end
      end
      DIV_FINISH: begin
        valid_o = 1'b1;
        // Hold the result until the commit stage takes it
        if (ready_i) begin
          ready_o = 1'b1;
          state_d = DIV_IDLE;
        end
      end
      default: state_d = DIV_IDLE;
    endcase

    // Dropped request aborts at any point
    if (!valid_i) begin
      state_d  = DIV_IDLE;
      valid_o  = 1'b0;
      ready_o  = 1'b1;
      init_en  = 1'b0;
      step_en  = 1'b0;
      dummy_en = 1'b0;
    end
  end

  // Control registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= DIV_IDLE;
      cnt_q      <= '0;
      comp_inv_q <= 1'b0;
      res_inv_q  <= 1'b0;
      div_rem_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (init_en) begin
        comp_inv_q <= op_b_neg;
        // Quotient of a zero divisor stays all ones
        res_inv_q  <= (!op_b_zero || div_rem) && signs_differ;
        div_rem_q  <= div_rem;
      end
    end
  end

endmodule

`default_nettype wire

/* source/ex_commit.sv */
`default_nettype none

module ex_commit import ex_op_pkg::*, ex_data_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Request side
  input  logic        valid_i,
  input  ex_unit_e    unit_i,
  output logic        ready_o,
  // Routing
  output logic        alu_valid_o,
  output logic        div_valid_o,
  // ALU side
  input  logic [31:0] alu_result_i,
  // Divider side
  input  logic        div_valid_i,
  input  logic [31:0] div_result_i,
  output logic        div_ready_o,
  // Output side
  output ex_res_t     res_o,
  output logic        valid_o,
  input  logic        ready_i
);

  logic    full_q;
  ex_res_t res_q;
  ex_res_t res_d;
  logic    can_load;
  logic    load_alu;
  logic    load_div;

  // Issue routing by unit
  assign alu_valid_o = valid_i && (unit_i == EX_UNIT_ALU);
  assign div_valid_o = valid_i && (unit_i == EX_UNIT_DIV);

  // Register free now or drained this cycle
  assign can_load = !full_q || ready_i;

  assign load_alu = alu_valid_o && can_load;
  // Divider only raises valid for its own request
  assign load_div = div_valid_i && can_load;

  // Divider waits in FINISH while the register is blocked
  assign div_ready_o = can_load;

  // Host sees the request taken once its result is loaded
  assign ready_o = !valid_i || load_alu || load_div;

  // Next register contents
  always_comb begin
    res_d.result   = load_div ? div_result_i : alu_result_i;
    res_d.from_div = load_div;
  end

  // Valid flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (load_alu || load_div) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (load_alu || load_div) begin
      res_q <= res_d;
    end
  end

  assign res_o   = res_q;
  assign valid_o = full_q;

endmodule

`default_nettype wire

/* source/ex_unit.sv */
`default_nettype none

module ex_unit import ex_data_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  ex_req_t req_i,
  input  logic    valid_i,
  output logic    ready_o,
  output ex_res_t res_o,
  output logic    valid_o,
  input  logic    ready_i
);

  // Issue routed to the divider
  logic        div_req_valid;
  // Divider use of the ALU
  logic        clz_en;
  logic [31:0] clz_data_rev;
  logic [5:0]  clz_result;
  logic        shift_en;
  logic [5:0]  shift_amt;
  logic [31:0] op_b_shifted;
  // Unit results
  logic [31:0] alu_result;
  logic        div_valid;
  logic [31:0] div_result;
  logic        div_ready;

  ex_alu u_alu (
    .op_i           (req_i.alu_op),
    .op_a_i         (req_i.op_a),
    .op_b_i         (req_i.op_b),
    .clz_en_i       (clz_en),
    .clz_data_rev_i (clz_data_rev),
    .shift_en_i     (shift_en),
    .shift_amt_i    (shift_amt),
    .clz_result_o   (clz_result),
    .op_b_shifted_o (op_b_shifted),
    .result_o       (alu_result)
  );

  // Input acceptance is rebuilt in the commit stage from the output handshake
  ex_div u_div (
    .clk                (clk),
    .rst_n              (rst_n),
    .operator_i         (req_i.div_op),
    .data_ind_timing_i  (req_i.data_ind_timing),
    .op_a_i             (req_i.op_a),
    .op_b_i             (req_i.op_b),
    .alu_clz_en_o       (clz_en),
    .alu_clz_data_rev_o (clz_data_rev),
    .alu_clz_result_i   (clz_result),
    .alu_shift_en_o     (shift_en),
    .alu_shift_amt_o    (shift_amt),
    .alu_op_b_shifted_i (op_b_shifted),
    .valid_i            (div_req_valid),
    .ready_o            (),
    .ready_i            (div_ready),
    .valid_o            (div_valid),
    .result_o           (div_result)
  );

  // ALU is purely combinational, its valid is only used inside the commit stage
  ex_commit u_commit (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .unit_i       (req_i.unit),
    .ready_o      (ready_o),
    .alu_valid_o  (),
    .div_valid_o  (div_req_valid),
    .alu_result_i (alu_result),
    .div_valid_i  (div_valid),
    .div_result_i (div_result),
    .div_ready_o  (div_ready),
    .res_o        (res_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i)
  );

endmodule

`default_nettype wire

/* tb/tb_ex_unit.sv */
`default_nettype none

module tb_ex_unit import ex_op_pkg::*, ex_data_pkg::*; ();

  // Cycle limit for every wait loop
  localparam int TIMEOUT = 300;

  logic    clk;
  logic    rst_n;
  ex_req_t req;
  logic    valid;
  logic    ready;
  ex_res_t res;
  logic    res_valid;
  logic    res_ready;

  integer      seed = 56;
  logic        bp_en;
  logic        alu_acc_q;
  ex_res_t     exp_q[$];
  ex_req_t     req_q[$];
  ex_req_t     mon_req;
  int          lat;
  int          lat_ref;
  logic [31:0] a;
  logic [31:0] b;
  logic        dit;

  alu_opcode_e alu_ops[6] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_CLZ};
  div_opcode_e div_ops[4] = '{DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU};

  ex_unit UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (req),
    .valid_i (valid),
    .ready_o (ready),
    .res_o   (res),
    .valid_o (res_valid),
    .ready_i (res_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and checking helpers
  //////////////////////////////////////////////////////////////////////

  // Expected result straight from the RISC-V arithmetic rules
  function automatic ex_res_t ref_result(input ex_req_t r);
    ex_res_t     e;
    logic [31:0] x;
    logic [31:0] y;
    logic        ovf;
    x = r.op_a;
    y = r.op_b;
    // Most negative dividend over minus one
    ovf = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
    e.from_div = (r.unit == EX_UNIT_DIV);
    e.result   = '0;
    if (r.unit == EX_UNIT_ALU) begin
      case (r.alu_op)
        ALU_ADD: e.result = x + y;
        ALU_SUB: e.result = x - y;
        ALU_SLL: e.result = x << y[4:0];
        ALU_SRL: e.result = x >> y[4:0];
        ALU_SRA: e.result = $signed(x) >>> y[4:0];
        ALU_CLZ: begin
          // Zero word counts as 32
          e.result = 32'd32;
          for (int i = 0; i < 32; i++) begin
            if (x[i]) begin
              e.result = 32'(31 - i);
            end
          end
        end
        default: e.result = '0;
      endcase
    end else begin
      case (r.div_op)
        DIV_DIV: begin
          if (y == 32'd0) e.result = '1;
          else if (ovf) e.result = x;
          else e.result = $signed(x) / $signed(y);
        end
        DIV_REM: begin
          if (y == 32'd0) e.result = x;
          else if (ovf) e.result = '0;
          else e.result = $signed(x) % $signed(y);
        end
        DIV_DIVU: begin
          if (y == 32'd0) e.result = '1;
          else e.result = x / y;
        end
        default: begin
          if (y == 32'd0) e.result = x;
          else e.result = x % y;
        end
      endcase
    end
    return e;
  endfunction

  function automatic ex_req_t make_req(input ex_unit_e unit, input alu_opcode_e aop,
                                       input div_opcode_e dop, input logic ind,
                                       input logic [31:0] x, input logic [31:0] y);
    ex_req_t r;
    r.unit            = unit;
    r.alu_op          = aop;
    r.div_op          = dop;
    r.data_ind_timing = ind;
    r.op_a            = x;
    r.op_b            = y;
    return r;
  endfunction

  task automatic stop_run(input string why);
    $display("error at %0t: %s", $time, why);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Holds the request until ready_o and returns the edges it took
  task automatic issue(input ex_req_t r, output int cycles);
    int t;
    req   <= r;
    valid <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) stop_run("timeout waiting for ready_o on an issued request");
    end while (!ready);
    valid  <= 1'b0;
    cycles = t;
  endtask

  // Wait until every accepted request has left on valid_o
  task automatic drain();
    int t;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) stop_run("timeout waiting for pending results to drain");
    end while ((exp_q.size() != 0) || res_valid);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Consumer side and compare process
  //////////////////////////////////////////////////////////////////////

  // Random back-pressure stalls about one cycle in four
  always @(posedge clk) begin
    if (bp_en) res_ready <= (($random(seed) & 3) != 0);
    else res_ready <= 1'b1;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      alu_acc_q <= 1'b0;
    end else begin
      // ALU result must be registered one edge after acceptance
      if (alu_acc_q) compare(res_valid, 1, "valid_o one cycle after ALU accept");
      if (res_valid && res_ready) begin
        if (exp_q.size() == 0) begin
          stop_run("result on valid_o with no request pending");
        end else begin
          mon_req = req_q.pop_front();
          compare(res, exp_q.pop_front(),
                  $sformatf("unit %0d alu_op %0d div_op %0d op_a %h op_b %h",
                            mon_req.unit, mon_req.alu_op, mon_req.div_op,
                            mon_req.op_a, mon_req.op_b));
        end
      end
      alu_acc_q <= valid && ready && (req.unit == EX_UNIT_ALU);
      if (valid && ready) begin
        exp_q.push_back(ref_result(req));
        req_q.push_back(req);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    req       = '0;
    valid     = 1'b0;
    res_ready = 1'b1;
    bp_en     = 1'b0;
    alu_acc_q = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    compare(res_valid, 0, "valid_o after reset");
    compare(ready, 1, "ready_o after reset");

    // Random ALU traffic accepted in one edge without stalls
    for (int i = 0; i < 60; i++) begin
      a = $random(seed);
      b = $random(seed);
      a = a >> b[9:5];
      issue(make_req(EX_UNIT_ALU, alu_ops[i % 6], DIV_DIV, 1'b0, a, b), lat);
      compare(lat, 1, "ALU accept cycles");
    end
    // Leading-zero edges
    issue(make_req(EX_UNIT_ALU, ALU_CLZ, DIV_DIV, 1'b0, 32'h0, 32'h0), lat);
    issue(make_req(EX_UNIT_ALU, ALU_CLZ, DIV_DIV, 1'b0, 32'h1, 32'h0), lat);
    issue(make_req(EX_UNIT_ALU, ALU_CLZ, DIV_DIV, 1'b0, 32'h8000_0000, 32'h0), lat);
    drain();

    // Random division with sign combinations cycling on i
    for (int i = 0; i < 48; i++) begin
      a   = $random(seed);
      b   = $random(seed);
      dit = $random(seed);
      b   = b >> b[4:0];
      a   = i[0] ? (a | 32'h8000_0000) : (a & 32'h7fff_ffff);
      b   = i[1] ? (32'd0 - b) : b;
      issue(make_req(EX_UNIT_DIV, ALU_ADD, div_ops[(i / 4) % 4], dit, a, b), lat);
    end
    drain();

    // Corner cases for every divider op
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      issue(make_req(EX_UNIT_DIV, ALU_ADD, div_ops[i % 4], i[2], a, 32'h0), lat);
      issue(make_req(EX_UNIT_DIV, ALU_ADD, div_ops[i % 4], i[2], 32'h8000_0000,
                     32'hffff_ffff), lat);
      issue(make_req(EX_UNIT_DIV, ALU_ADD, div_ops[i % 4], i[2], a, 32'h1), lat);
      issue(make_req(EX_UNIT_DIV, ALU_ADD, div_ops[i % 4], i[2], a, 32'hffff_ffff), lat);
      issue(make_req(EX_UNIT_DIV, ALU_ADD, div_ops[i % 4], i[2], 32'h0, a), lat);
      issue(make_req(EX_UNIT_DIV, ALU_ADD, div_ops[i % 4], i[2], 32'h0, 32'h0), lat);
    end
    drain();

    // Fixed latency across very different divisor lengths
    issue(make_req(EX_UNIT_DIV, ALU_ADD, DIV_DIVU, 1'b1, 32'hffff_ffff, 32'h1), lat_ref);
    drain();
    issue(make_req(EX_UNIT_DIV, ALU_ADD, DIV_DIVU, 1'b1, 32'h1234_5678, 32'h8000_0000), lat);
    compare(lat, lat_ref, "fixed latency, divisor with no leading zeros");
    drain();
    issue(make_req(EX_UNIT_DIV, ALU_ADD, DIV_DIV, 1'b1, 32'd100, 32'h0), lat);
    compare(lat, lat_ref, "fixed latency, zero divisor");
    drain();
    issue(make_req(EX_UNIT_DIV, ALU_ADD, DIV_REM, 1'b1, 32'hffff_fc18, 32'hffff_fffd), lat);
    compare(lat, lat_ref, "fixed latency, negative divisor");
    drain();
    issue(make_req(EX_UNIT_DIV, ALU_ADD, DIV_REMU, 1'b1, 32'd7, 32'h0001_0000), lat);
    compare(lat, lat_ref, "fixed latency, mid-range divisor");
    drain();

    // Mixed traffic under back-pressure
    bp_en <= 1'b1;
    for (int i = 0; i < 60; i++) begin
      a   = $random(seed);
      b   = $random(seed);
      dit = $random(seed);
      if (dit) begin
        issue(make_req(EX_UNIT_DIV, ALU_ADD, div_ops[i % 4], a[0], a, b >> b[4:0]), lat);
      end else begin
        issue(make_req(EX_UNIT_ALU, alu_ops[i % 6], DIV_DIV, 1'b0, a, b), lat);
      end
    end
    drain();
    bp_en <= 1'b0;
    drain();

    // Abort a division by dropping valid_i
    req   <= make_req(EX_UNIT_DIV, ALU_ADD, DIV_DIVU, 1'b1, 32'hdead_beef, 32'h3);
    valid <= 1'b1;
    repeat (6) @(posedge clk);
    compare(ready, 0, "ready_o in mid-division");
    valid <= 1'b0;
    repeat (40) begin
      @(posedge clk);
      compare(res_valid, 0, "valid_o after aborted division");
    end
    issue(make_req(EX_UNIT_DIV, ALU_ADD, DIV_REM, 1'b0, 32'hffff_ff9c, 32'd7), lat);
    drain();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* ex_unit.f */
source/ex_op_pkg.sv
source/ex_data_pkg.sv
source/ex_alu.sv
source/ex_div.sv
source/ex_commit.sv
source/ex_unit.sv
tb/tb_ex_unit.sv
